// File: design/cart_id_quirks.sv
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_id_quirks (
	input  logic                        clk_sys,
	input  logic                        rst_n,

	input  logic                        hdr_wr,
	input  cart_loader_pkg::dl_addr_t   hdr_addr,
	input  cart_loader_pkg::dl_word_t   hdr_data,
	input  logic                        dl_start,

	output cart_loader_pkg::quirk_vec_t quirks
);

	import cart_loader_pkg::*;

	cart_id_t cart_id;

	////////////////////////////////////////////////////////////////////////////
	// Product ID table
	////////////////////////////////////////////////////////////////////////////

	function automatic quirk_vec_t quirk_of(input cart_id_t id);
		quirk_vec_t v;
		v = '0;
		case (id)
			// Serial SRAM mapping
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				v[SRAM] = 1'b1;
			// Serial EEPROM saves
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				v[EEPROM] = 1'b1;
			"T-113016":
				v[NORAM] = 1'b1;   // Checks for absent RAM
			"T-89016 ":
				v[FIFO] = 1'b1;
			"T-574023", "T-574013":
				v[PIER] = 1'b1;
			"G-7001  ", "MK-1229 ":
				v[SVP] = 1'b1;   // DSP cartridge
			"T-35036 ", "T-25073 ", "MK-1137-":
				v[FMBUSY] = 1'b1;
			"T-68???-":
				v[SCHAN] = 1'b1;
			default:
				v = '0;
		endcase
		return v;
	endfunction

	// ID assembly in file byte order, first file byte sits in hdr_data[15:8]
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (hdr_addr)
				`HDR_ID_ADDR_FIRST:       cart_id[63:56] <= hdr_data[7:0];
				`HDR_ID_ADDR_FIRST + 'h2: cart_id[55:40] <= hdr_data;
				`HDR_ID_ADDR_FIRST + 'h4: cart_id[39:24] <= hdr_data;
				`HDR_ID_ADDR_FIRST + 'h6: cart_id[23:8]  <= hdr_data;
				`HDR_ID_ADDR_FIRST + 'h8: cart_id[7:0]   <= hdr_data[15:8];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			quirks <= '0;
		end else if (dl_start) begin
			quirks <= '0;   // New cartridge
		end else if (hdr_wr && hdr_addr == `HDR_ID_ADDR_MATCH) begin
			quirks <= quirks | quirk_of(cart_id);
		end
	end

	// One table entry per ID, so never two quirks at once
	a_one_quirk : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(quirks)
	) else $error("More than one quirk set: %h", quirks);

endmodule

// File: design/cart_loader_params.svh
`ifndef CART_LOADER_PARAMS_SVH
`define CART_LOADER_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Download bus widths
////////////////////////////////////////////////////////////////////////////

`define CART_ADDR_W 25   // Byte address from the host
`define CART_DATA_W 16   // One download word, low byte first in the file

// Number of compatibility quirk flags
`define QUIRK_COUNT 8

////////////////////////////////////////////////////////////////////////////
// Cartridge header byte addresses
////////////////////////////////////////////////////////////////////////////

// Product ID runs from 182h (second byte) up to 18Ah (first byte)
`define HDR_ID_ADDR_FIRST 'h182

// First word after the ID, table compare happens here
`define HDR_ID_ADDR_MATCH 'h18C

// Region letters
`define HDR_REGION_ADDR_A 'h1F0   // Both bytes used
`define HDR_REGION_ADDR_B 'h1F2   // First byte only

// Header fully received once this word is written
`define HDR_END_ADDR 'h200

`endif

// File: design/cart_loader_pkg.sv
`include "cart_loader_params.svh"

package cart_loader_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Region and auto region order
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Search order when picking a region from the header letters
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_t;

	////////////////////////////////////////////////////////////////////////////
	// Compatibility quirks
	////////////////////////////////////////////////////////////////////////////

	// Bit positions inside quirk_vec_t
	typedef enum logic [$clog2(`QUIRK_COUNT)-1:0] {
		SRAM, EEPROM, NORAM, FIFO, PIER, SVP, FMBUSY, SCHAN
	} quirk_t;

	typedef logic [`QUIRK_COUNT-1:0] quirk_vec_t;

	// Download side
	typedef logic [`CART_ADDR_W-1:0] dl_addr_t;
	typedef logic [`CART_DATA_W-1:0] dl_word_t;

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] cart_id_t;

endpackage

// File: design/cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                          clk_sys,
	input  logic                          rst_n,

	// Host download
	input  logic                          download,
	input  logic                          dl_wr,
	input  cart_loader_pkg::dl_addr_t     dl_addr,
	input  cart_loader_pkg::dl_word_t     dl_data,
	output logic                          dl_wait,

	// ROM memory
	output logic                          rom_wr_req,
	input  logic                          rom_wr_ack,
	output cart_loader_pkg::dl_addr_t     rom_wr_addr,
	output cart_loader_pkg::dl_word_t     rom_wr_data,
	output cart_loader_pkg::dl_addr_t     rom_size,

	// Region control
	input  logic                          auto_region_off,
	input  logic                          region_from_header,
	input  cart_loader_pkg::region_prio_t region_prio,
	input  logic [7:0]                    file_index,
	output cart_loader_pkg::region_t      region_req,
	output logic                          region_set,

	output cart_loader_pkg::quirk_vec_t   quirks
);

	import cart_loader_pkg::*;

	logic     hdr_wr;
	dl_addr_t hdr_addr;
	dl_word_t hdr_data;
	logic     dl_start;
	logic     dl_end;
	logic     hdr_j;
	logic     hdr_u;
	logic     hdr_e;
	logic     hdr_ready;

	rom_write_port rom_write_port_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.download    (download),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wait     (dl_wait),
		.rom_wr_req  (rom_wr_req),
		.rom_wr_ack  (rom_wr_ack),
		.rom_wr_addr (rom_wr_addr),
		.rom_wr_data (rom_wr_data),
		.rom_size    (rom_size),
		.hdr_wr      (hdr_wr),
		.hdr_addr    (hdr_addr),
		.hdr_data    (hdr_data),
		.dl_start    (dl_start),
		.dl_end      (dl_end)
	);

	// Both scanners watch the same registered stream
	header_region_scan header_region_scan_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.hdr_wr    (hdr_wr),
		.hdr_addr  (hdr_addr),
		.hdr_data  (hdr_data),
		.dl_start  (dl_start),
		.dl_end    (dl_end),
		.hdr_j     (hdr_j),
		.hdr_u     (hdr_u),
		.hdr_e     (hdr_e),
		.hdr_ready (hdr_ready)
	);

	cart_id_quirks cart_id_quirks_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.hdr_wr   (hdr_wr),
		.hdr_addr (hdr_addr),
		.hdr_data (hdr_data),
		.dl_start (dl_start),
		.quirks   (quirks)
	);

	region_policy region_policy_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.hdr_ready          (hdr_ready),
		.hdr_j              (hdr_j),
		.hdr_u              (hdr_u),
		.hdr_e              (hdr_e),
		.auto_region_off    (auto_region_off),
		.region_from_header (region_from_header),
		.region_prio        (region_prio),
		.file_index         (file_index),
		.region_req         (region_req),
		.region_set         (region_set)
	);

endmodule

// File: design/header_region_scan.sv
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module header_region_scan (
	input  logic                      clk_sys,
	input  logic                      rst_n,

	// Registered download stream, bytes already swapped
	input  logic                      hdr_wr,
	input  cart_loader_pkg::dl_addr_t hdr_addr,
	input  cart_loader_pkg::dl_word_t hdr_data,
	input  logic                      dl_start,
	input  logic                      dl_end,

	output logic                      hdr_j,
	output logic                      hdr_u,
	output logic                      hdr_e,
	output logic                      hdr_ready
);

	logic [2:0] hit_a;   // {j, u, e} from the first file byte
	logic [2:0] hit_b;   // {j, u, e} from the second file byte
	logic [2:0] hit;

	// Classify one region character
	function automatic logic [2:0] region_letter(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		if (c == "J")
			f = 3'b100;
		else if (c == "U")
			f = 3'b010;
		else if (c >= "0" && c <= "Z")
			f = 3'b001;   // Any other code counts as Europe
		return f;
	endfunction

	always_comb begin
		hit_a = 3'b000;
		hit_b = 3'b000;
		if (hdr_addr == `HDR_REGION_ADDR_A || hdr_addr == `HDR_REGION_ADDR_B)
			hit_a = region_letter(hdr_data[15:8]);
		if (hdr_addr == `HDR_REGION_ADDR_A)
			hit_b = region_letter(hdr_data[7:0]);   // Second byte only in the first word
		hit = hit_a | hit_b;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sticky flags and header ready
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_e     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			if (dl_start) begin
				hdr_j <= 1'b0;
				hdr_u <= 1'b0;
				hdr_e <= 1'b0;
			end else if (hdr_wr) begin
				hdr_j <= hdr_j | hit[2];
				hdr_u <= hdr_u | hit[1];
				hdr_e <= hdr_e | hit[0];
			end

			if (dl_end)
				hdr_ready <= 1'b0;
			else if (hdr_wr && hdr_addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;   // Whole header seen
		end
	end

endmodule

// File: design/region_policy.sv
`timescale 1ns/1ps

module region_policy (
	input  logic                          clk_sys,
	input  logic                          rst_n,

	// From header_region_scan
	input  logic                          hdr_ready,
	input  logic                          hdr_j,
	input  logic                          hdr_u,
	input  logic                          hdr_e,

	// Policy selection
	input  logic                          auto_region_off,
	input  logic                          region_from_header,
	input  cart_loader_pkg::region_prio_t region_prio,
	input  logic [7:0]                    file_index,

	output cart_loader_pkg::region_t      region_req,
	output logic                          region_set
);

	import cart_loader_pkg::*;

	logic    ready_q;
	region_t hdr_pick;

	// First present region in the chosen order, else the order's first entry
	always_comb begin
		case (region_prio)
			US_EU_JP: hdr_pick = hdr_u ? US : hdr_e ? EU : hdr_j ? JP : US;
			EU_US_JP: hdr_pick = hdr_e ? EU : hdr_u ? US : hdr_j ? JP : EU;
			US_JP_EU: hdr_pick = hdr_u ? US : hdr_j ? JP : hdr_e ? EU : US;
			JP_US_EU: hdr_pick = hdr_j ? JP : hdr_u ? US : hdr_e ? EU : JP;
			default:  hdr_pick = US;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Region request on header ready
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ready_q    <= 1'b0;
			region_set <= 1'b0;
			region_req <= JP;
		end else begin
			ready_q <= hdr_ready;

			if (hdr_ready && !ready_q && !auto_region_off) begin
				if (region_from_header) begin
					region_set <= 1'b1;
					region_req <= hdr_pick;
				end else begin
					// Region coded in the top bits of the file index
					region_set <= |file_index;
					region_req <= region_t'(file_index[7:6]);
				end
			end else if (!hdr_ready && ready_q) begin
				region_set <= 1'b0;   // Header gone after download end
			end
		end
	end

endmodule

// File: design/rom_write_port.sv
`timescale 1ns/1ps

module rom_write_port (
	input  logic                      clk_sys,
	input  logic                      rst_n,

	// Host download side
	input  logic                      download,
	input  logic                      dl_wr,
	input  cart_loader_pkg::dl_addr_t dl_addr,
	input  cart_loader_pkg::dl_word_t dl_data,
	output logic                      dl_wait,

	// ROM memory write side
	output logic                      rom_wr_req,
	input  logic                      rom_wr_ack,
	output cart_loader_pkg::dl_addr_t rom_wr_addr,
	output cart_loader_pkg::dl_word_t rom_wr_data,
	output cart_loader_pkg::dl_addr_t rom_size,

	// Registered word stream for the header scanners
	output logic                      hdr_wr,
	output cart_loader_pkg::dl_addr_t hdr_addr,
	output cart_loader_pkg::dl_word_t hdr_data,
	output logic                      dl_start,
	output logic                      dl_end
);

	logic download_q;

	// Download edges, valid for one cycle
	assign dl_start = download & ~download_q;
	assign dl_end   = ~download & download_q;

	////////////////////////////////////////////////////////////////////////////
	// Toggle handshake and host wait
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			dl_wait    <= 1'b0;
			rom_wr_req <= 1'b0;
			hdr_wr     <= 1'b0;
		end else begin
			download_q <= download;
			hdr_wr     <= dl_wr & download;   // One pulse per accepted word

			if (dl_end)
				dl_wait <= 1'b0;

			if (dl_start) begin
				rom_wr_req <= 1'b0;
			end else if (download) begin
				if (dl_wr) begin
					rom_wr_req <= ~rom_wr_req;   // New request
					dl_wait    <= 1'b1;
				end else if (dl_wait && (rom_wr_req == rom_wr_ack)) begin
					dl_wait <= 1'b0;   // Memory has caught up
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address, data and ROM size
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (dl_wr && download) begin
			rom_wr_addr <= dl_addr;
			rom_wr_data <= {dl_data[7:0], dl_data[15:8]};   // File order to memory order
		end
		if (dl_end)
			rom_size <= dl_addr;   // Last address the host presented
	end

	// Scanners see exactly what memory gets
	assign hdr_addr = rom_wr_addr;
	assign hdr_data = rom_wr_data;

	// Host must respect the wait level
	a_no_wr_while_wait : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		dl_wr |-> !dl_wait
	) else $error("dl_wr while dl_wait is high");

endmodule

// File: sim/cart_loader_tb.sv
`timescale 1ns/1ps
`include "cart_loader_params.svh"

module cart_loader_tb;

	import cart_loader_pkg::*;

	localparam int IMG_BYTES     = 'h220;
	localparam int IMG_WORDS     = IMG_BYTES / 2;
	localparam int NUM_DOWNLOADS = 20;   // 16 priority runs, 3 file index, 1 auto off
	localparam int WORD_CYCLES   = 6;    // Strobe, up to 4 ack cycles, wait fall
	localparam int DL_OVERHEAD   = 8;
	localparam int TIMEOUT_CYCLES =
		2 * (4 + NUM_DOWNLOADS * (IMG_WORDS * WORD_CYCLES + DL_OVERHEAD));

	logic         clk_sys = 1'b0;
	logic         rst_n;
	logic         download;
	logic         dl_wr;
	dl_addr_t     dl_addr;
	dl_word_t     dl_data;
	logic         dl_wait;
	logic         rom_wr_req;
	logic         rom_wr_ack;
	dl_addr_t     rom_wr_addr;
	dl_word_t     rom_wr_data;
	dl_addr_t     rom_size;
	logic         auto_region_off;
	logic         region_from_header;
	region_prio_t region_prio;
	logic [7:0]   file_index;
	region_t      region_req;
	logic         region_set;
	quirk_vec_t   quirks;

	integer     seed = 32'h49e9;
	int         error_count = 0;
	int         cycle_count = 0;
	int         dl_count = 0;
	logic [7:0] img [0:IMG_BYTES-1];        // File bytes of the current download
	dl_word_t   mem_model [0:IMG_WORDS-1];  // What memory received
	cart_id_t   id_list [0:9];

	cart_loader_top cart_loader_top_i (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// {j, u, e} for one region character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		if (c == "J")
			return 3'b100;
		if (c == "U")
			return 3'b010;
		if (c >= "0" && c <= "Z")
			return 3'b001;
		return 3'b000;
	endfunction

	// {region_set, region_req} once the header is ready
	function automatic logic [2:0] expected_region(input logic [2:0] flags,
			input logic auto_off, input logic from_header, input logic [1:0] prio,
			input logic [7:0] index);
		logic [5:0] order;   // First choice in the top bits
		logic [1:0] r;
		logic [1:0] pick;
		logic       found;
		int         k;
		if (auto_off)
			return 3'b000;
		if (!from_header)
			return {|index, index[7:6]};
		case (prio)
			2'd0:    order = {US, EU, JP};
			2'd1:    order = {EU, US, JP};
			2'd2:    order = {US, JP, EU};
			default: order = {JP, US, EU};
		endcase
		pick  = order[5:4];   // No letter at all
		found = 1'b0;
		for (k = 0; k < 3; k++) begin
			r = order[5-2*k -: 2];
			if (!found && ((r == JP && flags[2]) || (r == US && flags[1]) ||
					(r == EU && flags[0]))) begin
				pick  = r;
				found = 1'b1;
			end
		end
		return {1'b1, pick};
	endfunction

	function automatic quirk_vec_t expected_quirks(input cart_id_t id);
		quirk_vec_t v;
		v = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				v[SRAM] = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				v[EEPROM] = 1'b1;
			"T-113016": v[NORAM] = 1'b1;
			"T-89016 ": v[FIFO] = 1'b1;
			"T-574023", "T-574013": v[PIER] = 1'b1;
			"G-7001  ", "MK-1229 ": v[SVP] = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": v[FMBUSY] = 1'b1;
			"T-68???-": v[SCHAN] = 1'b1;
			default: v = '0;
		endcase
		return v;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory side and host side
	////////////////////////////////////////////////////////////////////////////

	initial begin : memory_responder
		int delay;
		rom_wr_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && rom_wr_req !== rom_wr_ack) begin
				check("rom_wr_addr in image", rom_wr_addr < IMG_BYTES, 1'b1);
				mem_model[rom_wr_addr[9:1]] = rom_wr_data;
				delay = 1 + ($unsigned($random(seed)) % 4);   // Variable latency
				repeat (delay) @(posedge clk_sys);
				#1;
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	// Called 1 ns after an edge, returns 1 ns after an edge
	task automatic write_word(input dl_addr_t addr, input dl_word_t data,
			input logic wait_release);
		logic prev_req;
		prev_req = rom_wr_req;
		dl_wr    = 1'b1;
		dl_addr  = addr;
		dl_data  = data;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		check("rom_wr_req", rom_wr_req, !prev_req);
		check("dl_wait", dl_wait, 1'b1);
		if (wait_release) begin
			while (dl_wait) begin
				@(posedge clk_sys);
				#1;
			end
			check("rom_wr_ack", rom_wr_ack, rom_wr_req);   // Nothing pending once released
		end
	endtask

	task automatic run_download(input int hdr_case, input cart_id_t id);
		logic [2:0] exp_flags;
		logic [2:0] exp_region;
		int         a;
		for (a = 0; a < IMG_BYTES; a++)
			img[a] = a[7:0] ^ {4{a[9:8]}} ^ (dl_count[7:0] * 8'h3b);
		for (a = 0; a < IMG_WORDS; a++)
			mem_model[a] = 'x;
		img[`HDR_REGION_ADDR_A]     = " ";
		img[`HDR_REGION_ADDR_A + 1] = " ";
		img[`HDR_REGION_ADDR_B]     = " ";
		img[`HDR_REGION_ADDR_B + 1] = "J";   // Never examined
		case (hdr_case)
			1: img[`HDR_REGION_ADDR_A] = "J";
			2: img[`HDR_REGION_ADDR_B] = "E";
			3: begin
				img[`HDR_REGION_ADDR_A]     = "U";
				img[`HDR_REGION_ADDR_A + 1] = "J";
				img[`HDR_REGION_ADDR_B]     = "8";   // Digit counts as Europe
			end
			default: ;
		endcase
		for (a = 0; a < 8; a++)
			img[`HDR_ID_ADDR_FIRST + 1 + a] = id[63-8*a -: 8];
		exp_flags = letter_flags(img[`HDR_REGION_ADDR_A]) |
			letter_flags(img[`HDR_REGION_ADDR_A + 1]) | letter_flags(img[`HDR_REGION_ADDR_B]);

		download = 1'b1;
		@(posedge clk_sys);
		#1;
		check("quirks", quirks, 0);   // Previous cartridge forgotten
		check("rom_wr_req", rom_wr_req, 1'b0);
		for (a = 0; a < IMG_BYTES; a += 2)
			write_word(a, {img[a+1], img[a]}, a < IMG_BYTES - 2);   // Last write left pending

		check("hdr_ready", cart_loader_top_i.hdr_ready, 1'b1);
		check("hdr_jue", {cart_loader_top_i.hdr_j, cart_loader_top_i.hdr_u,
			cart_loader_top_i.hdr_e}, exp_flags);
		check("quirks", quirks, expected_quirks(id));
		exp_region = expected_region(exp_flags, auto_region_off, region_from_header,
			region_prio, file_index);
		check("region_set", region_set, exp_region[2]);
		if (!auto_region_off)
			check("region_req", region_req, exp_region[1:0]);

		download = 1'b0;   // Falls while memory still holds the last word
		@(posedge clk_sys);
		#1;
		check("rom_size", rom_size, IMG_BYTES - 2);
		check("dl_wait", dl_wait, 1'b0);
		check("hdr_ready", cart_loader_top_i.hdr_ready, 1'b0);
		@(posedge clk_sys);
		#1;
		check("region_set", region_set, 1'b0);
		wait (rom_wr_ack === rom_wr_req);
		@(posedge clk_sys);
		#1;
		for (a = 0; a < IMG_WORDS; a++)
			check("rom_wr_data", mem_model[a], {img[2*a], img[2*a+1]});   // Swapped
		dl_count++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int p;
		int h;
		int n;
		rst_n              = 1'b0;
		download           = 1'b0;
		dl_wr              = 1'b0;
		dl_addr            = '0;
		dl_data            = '0;
		auto_region_off    = 1'b0;
		region_from_header = 1'b1;
		region_prio        = US_EU_JP;
		file_index         = 8'h00;
		id_list[0] = "T-081276";
		id_list[1] = "MK-1215 ";
		id_list[2] = "T-113016";
		id_list[3] = "T-89016 ";
		id_list[4] = "T-574023";
		id_list[5] = "G-7001  ";
		id_list[6] = "T-35036 ";
		id_list[7] = "T-68???-";
		id_list[8] = "00054010";   // Not in the table
		id_list[9] = "T-25073 ";

		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		check("dl_wait", dl_wait, 1'b0);
		check("rom_wr_req", rom_wr_req, 1'b0);
		check("region_set", region_set, 1'b0);
		check("hdr_ready", cart_loader_top_i.hdr_ready, 1'b0);
		check("quirks", quirks, 0);

		// Every priority order against every header letter mix
		n = 0;
		for (p = 0; p < 4; p++) begin
			for (h = 0; h < 4; h++) begin
				region_prio = region_prio_t'(p[1:0]);
				run_download(h, id_list[n % 10]);
				n++;
			end
		end

		region_from_header = 1'b0;
		file_index = 8'h47;
		run_download(3, id_list[n % 10]);
		n++;
		file_index = 8'h85;
		run_download(1, id_list[n % 10]);
		n++;
		file_index = 8'h00;   // No region request at all
		run_download(2, id_list[n % 10]);
		n++;
		auto_region_off    = 1'b1;
		region_from_header = 1'b1;
		file_index         = 8'h47;
		run_download(3, id_list[n % 10]);

		if (error_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule

// File: sources.f
+incdir+design
design/cart_loader_pkg.sv
design/rom_write_port.sv
design/header_region_scan.sv
design/cart_id_quirks.sv
design/region_policy.sv
design/cart_loader_top.sv
sim/cart_loader_tb.sv
